//--- brightness_timeout.sv
// ======================================================================
// weighted lit time per bit plane, base timeout shifted by plane index
// mask_active must already hold the new plane during row_latch
// ======================================================================
`timescale 1ns/1ps

module brightness_timeout (
    input  logic                                     clk_in,
    input  logic                                     reset,
    input  logic                                     row_latch,
    input  logic [matrix_pkg::brightness_levels-1:0] mask_active,
    output logic                                     output_enable,
    output logic                                     in_overlap
);

    logic [matrix_pkg::timer_bits-1:0] duration;
    logic [matrix_pkg::timer_bits-1:0] remaining;

    // one-hot plane to its weight
    always_comb begin
        duration = '0;
        for (int b = 0; b < matrix_pkg::brightness_levels; b++) begin
            if (mask_active[b]) begin
                duration = duration |
                    matrix_pkg::timer_bits'(matrix_pkg::brightness_base_timeout << b);
            end
        end
    end

    // loaded on row_latch, lit from the next cycle on
    scan_timer #(
        .counter_width(matrix_pkg::timer_bits)
    ) u_lit_timer (
        .clk_in  (clk_in),
        .reset   (reset),
        .start   (row_latch),
        .value   (duration),
        .count   (remaining),
        .running (output_enable)
    );

    // next line may begin shifting while the tail is still lit
    assign in_overlap = output_enable &&
        (remaining <= matrix_pkg::timer_bits'(matrix_pkg::brightness_overlap));

endmodule

//--- frame_buffer.sv
// ======================================================================
// APB3 slave over the pixel memory, zero wait states, never stalls
// byte addresses at or above fb_depth*4 give pslverr, writes dropped
// ======================================================================
`timescale 1ns/1ps

module frame_buffer (
    input  logic                                clk_in,
    input  logic                                reset,
    input  logic [matrix_pkg::apb_addr_bits-1:0] paddr,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [31:0]                         pwdata,
    output logic [31:0]                         prdata,
    output logic                                pready,
    output logic                                pslverr,
    input  logic [matrix_pkg::fb_addr_bits-1:0]  rd_addr_upper,
    input  logic [matrix_pkg::fb_addr_bits-1:0]  rd_addr_lower,
    output matrix_pkg::pixel_t                  rd_pixel_upper,
    output matrix_pkg::pixel_t                  rd_pixel_lower
);

    matrix_pkg::pixel_t mem [matrix_pkg::fb_depth];

    logic [matrix_pkg::fb_addr_bits-1:0] word_addr;
    logic addr_err;
    logic setup_phase;
    logic access_phase;

    // byte lane bits ignored
    assign word_addr = paddr[matrix_pkg::fb_addr_bits+1:2];
    // any bit above the pixel space
    assign addr_err = |paddr[matrix_pkg::apb_addr_bits-1:matrix_pkg::fb_addr_bits+2];

    assign setup_phase = psel && !penable;
    assign access_phase = psel && penable;

    // zero wait states
    assign pready = 1'b1;

    // write lands at the end of the access phase
    always_ff @(posedge clk_in) begin
        if (access_phase && pwrite && !addr_err) begin
            mem[word_addr] <= pwdata[$bits(matrix_pkg::pixel_t)-1:0];
        end
    end

    // read data sampled in setup, valid through the access phase
    always_ff @(posedge clk_in) begin
        if (setup_phase && !pwrite) begin
            prdata <= addr_err ? '0 : 32'(mem[word_addr]);
        end
    end

    // error decoded in setup so it is up for the whole access phase
    always_ff @(posedge clk_in) begin
        if (reset) begin
            pslverr <= 1'b0;
        end else begin
            pslverr <= setup_phase && addr_err;
        end
    end

    // scan side, one cycle latency on both halves
    always_ff @(posedge clk_in) begin
        rd_pixel_upper <= mem[rd_addr_upper];
        rd_pixel_lower <= mem[rd_addr_lower];
    end

endmodule

//--- led_matrix_top.sv
// ======================================================================
// HUB75 32x16 driver with APB3 frame buffer, single clock domain
// pixel_clk is a registered output, no back-pressure from the panel
// ======================================================================
`timescale 1ns/1ps

module led_matrix_top (
    input  logic                                 clk_in,
    input  logic                                 reset,
    // apb3 slave
    input  logic [matrix_pkg::apb_addr_bits-1:0] paddr,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [31:0]                          pwdata,
    output logic [31:0]                          prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    // hub75 panel
    output logic                                 pixel_clk,
    output logic                                 r0,
    output logic                                 g0,
    output logic                                 b0,
    output logic                                 r1,
    output logic                                 g1,
    output logic                                 b1,
    output logic                                 row_latch,
    output logic                                 output_enable,
    output logic [matrix_pkg::row_bits-1:0]      row_address
);

    logic [matrix_pkg::fb_addr_bits-1:0] rd_addr_upper;
    logic [matrix_pkg::fb_addr_bits-1:0] rd_addr_lower;
    matrix_pkg::pixel_t rd_pixel_upper;
    matrix_pkg::pixel_t rd_pixel_lower;

    scan_if scan_bus ();

    matrix_scan u_scan (
        .clk_in        (clk_in),
        .reset         (reset),
        .scan          (scan_bus.ctrl),
        .row_latch     (row_latch),
        .row_address   (row_address),
        .output_enable (output_enable)
    );

    pixel_shifter u_shifter (
        .clk_in         (clk_in),
        .reset          (reset),
        .scan           (scan_bus.shift),
        .rd_addr_upper  (rd_addr_upper),
        .rd_addr_lower  (rd_addr_lower),
        .rd_pixel_upper (rd_pixel_upper),
        .rd_pixel_lower (rd_pixel_lower),
        .pixel_clk      (pixel_clk),
        .r0             (r0),
        .g0             (g0),
        .b0             (b0),
        .r1             (r1),
        .g1             (g1),
        .b1             (b1)
    );

    frame_buffer u_frame_buffer (
        .clk_in         (clk_in),
        .reset          (reset),
        .paddr          (paddr),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .rd_addr_upper  (rd_addr_upper),
        .rd_addr_lower  (rd_addr_lower),
        .rd_pixel_upper (rd_pixel_upper),
        .rd_pixel_lower (rd_pixel_lower)
    );

endmodule

//--- matrix_checks.sv
// ======================================================================
// panel model and assertions for led_matrix_top, one sample per cycle
// samples at the falling edge of clk_in, shadow only tracks APB writes
// ======================================================================
`timescale 1ns/1ps

module matrix_checks (
    input logic                                 clk_in,
    input logic                                 reset,
    input logic                                 check_data,
    input logic [matrix_pkg::apb_addr_bits-1:0] paddr,
    input logic                                 psel,
    input logic                                 penable,
    input logic                                 pwrite,
    input logic [31:0]                          pwdata,
    input logic [31:0]                          prdata,
    input logic                                 pready,
    input logic                                 pslverr,
    input logic                                 pixel_clk,
    input logic                                 r0,
    input logic                                 g0,
    input logic                                 b0,
    input logic                                 r1,
    input logic                                 g1,
    input logic                                 b1,
    input logic                                 row_latch,
    input logic                                 output_enable,
    input logic [matrix_pkg::row_bits-1:0]      row_address
);

    // shadow of every pixel written over APB
    matrix_pkg::pixel_t shadow [matrix_pkg::fb_depth];
    bit written [matrix_pkg::fb_depth];

    // per behavior, index 1 to 6
    int err_count [1:6] = '{default: 0};
    int hit_count [1:6] = '{default: 0};
    int latch_count;

    // line being shifted, plane 3 is the msb
    int line_row;
    int line_plane;
    int edges;
    int lit_plane;
    int lit_len;
    bit lit_active;
    bit data_live;
    logic pclk_d;
    logic [matrix_pkg::row_bits-1:0] row_d;
    int word;
    int col;
    bit bad_addr;
    matrix_pkg::pixel_t upper;
    matrix_pkg::pixel_t lower;
    logic [5:0] expected;

    task automatic note_mismatch(input int test, input string msg);
        err_count[test]++;
        $display("mismatch at %0t: test %0d, %s", $time, test, msg);
    endtask

    always @(negedge clk_in) begin
        if (reset) begin
            line_row = 0;
            line_plane = matrix_pkg::brightness_levels - 1;
            edges = 0;
            lit_active = 0;
            data_live = 0;
            latch_count = 0;
            pclk_d = 1'b0;
            row_d = '0;
            hit_count[6]++;
            assert (!pixel_clk && !row_latch && !output_enable && !pslverr)
                else note_mismatch(6, "panel or APB outputs not idle in reset");
        end else begin
            // apb access phase
            if (psel && penable) begin
                word = int'(paddr) >> 2;
                bad_addr = int'(paddr) >= matrix_pkg::fb_depth * 4;
                hit_count[1]++;
                assert (pready) else note_mismatch(1, "pready low in access phase");
                assert (pslverr == bad_addr)
                    else note_mismatch(1, $sformatf("pslverr %b at address %h", pslverr, paddr));
                if (!bad_addr && pwrite) begin
                    shadow[word] = pwdata[$bits(matrix_pkg::pixel_t)-1:0];
                    written[word] = 1'b1;
                end else if (!bad_addr && written[word]) begin
                    assert (prdata == 32'(shadow[word]))
                        else note_mismatch(1, $sformatf("read %h got %h expected %h",
                            paddr, prdata, 32'(shadow[word])));
                end
            end
            // lit window closes on the first dark cycle
            if (lit_active) begin
                if (output_enable) begin
                    lit_len++;
                end else begin
                    hit_count[5]++;
                    assert (lit_len == (matrix_pkg::brightness_base_timeout << lit_plane))
                        else note_mismatch(5, $sformatf("plane %0d lit %0d cycles",
                            lit_plane, lit_len));
                    lit_active = 0;
                end
            end
            if (pixel_clk && !pclk_d) begin
                // msb plane is still lit when the next line starts shifting
                if (edges == 0 && latch_count > 0 &&
                        lit_plane == matrix_pkg::brightness_levels - 1) begin
                    hit_count[6]++;
                    assert (output_enable)
                        else note_mismatch(6, "msb plane dark before next line shifts");
                end
                if (data_live && edges < matrix_pkg::panel_width) begin
                    col = matrix_pkg::panel_width - 1 - edges;
                    upper = shadow[line_row * matrix_pkg::panel_width + col];
                    lower = shadow[(line_row + matrix_pkg::panel_halfheight) *
                        matrix_pkg::panel_width + col];
                    expected = {upper.red[line_plane], upper.green[line_plane],
                        upper.blue[line_plane], lower.red[line_plane],
                        lower.green[line_plane], lower.blue[line_plane]};
                    hit_count[3]++;
                    assert ({r0, g0, b0, r1, g1, b1} == expected)
                        else note_mismatch(3, $sformatf("row %0d col %0d plane %0d got %b exp %b",
                            line_row, col, line_plane, {r0, g0, b0, r1, g1, b1}, expected));
                end
                edges++;
            end
            if (row_latch) begin
                hit_count[2]++;
                assert (edges == matrix_pkg::panel_width)
                    else note_mismatch(2, $sformatf("%0d pixel_clk edges in line", edges));
                hit_count[4]++;
                assert (int'(row_address) == line_row)
                    else note_mismatch(4, $sformatf("row_address %0d expected %0d",
                        row_address, line_row));
                hit_count[6]++;
                assert (!output_enable) else note_mismatch(6, "row_latch while lit");
                edges = 0;
                lit_active = 1;
                lit_len = 0;
                lit_plane = line_plane;
                data_live = check_data;
                latch_count++;
                // msb first, next row after the lsb plane
                if (line_plane == 0) begin
                    line_plane = matrix_pkg::brightness_levels - 1;
                    line_row = (line_row + 1) % matrix_pkg::panel_halfheight;
                end else begin
                    line_plane--;
                end
            end else begin
                assert (row_address == row_d)
                    else note_mismatch(4, "row_address moved without row_latch");
            end
            row_d = row_address;
            pclk_d = pixel_clk;
        end
    end

endmodule

//--- matrix_pkg.sv
// ======================================================================
// 32x16 panel scanned as two halves of 8 rows, RGB444 pixels.
// frame buffer holds all 512 pixels, APB byte address = pixel * 4
// the APB window is 4 KiB and anything at or above 2 KiB errors
// ======================================================================
package matrix_pkg;

    // panel geometry
    localparam int panel_width = 32;
    localparam int panel_halfheight = 8;
    localparam int column_bits = $clog2(panel_width);
    localparam int row_bits = $clog2(panel_halfheight);

    // binary-coded modulation
    localparam int brightness_levels = 4;
    // lit time of the lsb plane, in clk_in cycles
    localparam int brightness_base_timeout = 4;
    // remaining lit time below which the next line may shift
    localparam int brightness_overlap = 40;
    localparam int timer_bits = 8;
    localparam logic [brightness_levels-1:0] plane_msb = 1 << (brightness_levels - 1);

    // pixel memory, both halves
    localparam int fb_depth = 2 * panel_halfheight * panel_width;
    localparam int fb_addr_bits = $clog2(fb_depth);

    // apb byte address, word aligned pixels
    localparam int apb_addr_bits = 12;

    typedef struct packed {
        logic [brightness_levels-1:0] red;
        logic [brightness_levels-1:0] green;
        logic [brightness_levels-1:0] blue;
    } pixel_t;

endpackage

//--- matrix_scan.sv
// ======================================================================
// line sequencer: 32 fetches on alternate cycles, then latch
// latch waits for the 3-cycle shifter pipeline and a dark panel
// ======================================================================
`timescale 1ns/1ps

module matrix_scan (
    input  logic                            clk_in,
    input  logic                            reset,
    scan_if.ctrl                            scan,
    output logic                            row_latch,
    output logic [matrix_pkg::row_bits-1:0] row_address,
    output logic                            output_enable
);

    typedef enum logic [1:0] {
        st_idle,
        st_shift,
        st_wait_latch,
        st_latch
    } state_t;

    state_t state;
    logic phase;
    logic line_done_d;
    logic start_ok;
    logic last_fetch;
    logic drained;
    logic in_overlap;
    logic col_start;
    logic col_running;
    logic [matrix_pkg::column_bits-1:0] col_count;
    logic [matrix_pkg::column_bits-1:0] col_value;
    logic [matrix_pkg::row_bits-1:0] shift_row;
    logic [matrix_pkg::brightness_levels-1:0] shift_mask;
    logic [matrix_pkg::brightness_levels-1:0] mask_active;

    // dark panel, or lit but inside the overlap tail
    assign start_ok = !output_enable || in_overlap;

    // fetch on even cycles of the shift
    assign scan.fetch = (state == st_shift) && !phase;
    assign last_fetch = scan.fetch && !col_running;

    // nothing left in the shifter two cycles after line_done
    assign drained = !scan.line_done && !line_done_d;

    // load the last column at line start, hold it on odd cycles
    assign col_start = ((state == st_idle) && start_ok) || ((state == st_shift) && phase);
    assign col_value = (state == st_idle) ?
        matrix_pkg::column_bits'(matrix_pkg::panel_width - 1) : col_count;

    scan_timer #(
        .counter_width(matrix_pkg::column_bits)
    ) u_column_timer (
        .clk_in  (clk_in),
        .reset   (reset),
        .start   (col_start),
        .value   (col_value),
        .count   (col_count),
        .running (col_running)
    );

    assign scan.column = col_count;
    assign scan.row = shift_row;
    assign scan.mask = shift_mask;
    assign row_latch = (state == st_latch);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= st_idle;
            phase <= 1'b0;
            scan.line_done <= 1'b0;
            line_done_d <= 1'b0;
            shift_row <= '0;
            shift_mask <= matrix_pkg::plane_msb;
            row_address <= '0;
            mask_active <= '0;
        end else begin
            scan.line_done <= last_fetch;
            line_done_d <= scan.line_done;
            phase <= (state == st_shift) && !phase;
            case (state)
                st_idle: begin
                    if (start_ok) begin
                        state <= st_shift;
                    end
                end
                st_shift: begin
                    if (last_fetch) begin
                        state <= st_wait_latch;
                    end
                end
                st_wait_latch: begin
                    if (drained && !output_enable) begin
                        state <= st_latch;
                        // active values are valid during the latch cycle
                        row_address <= shift_row;
                        mask_active <= shift_mask;
                        // msb first, row steps after the lsb plane
                        if (shift_mask[0]) begin
                            shift_mask <= matrix_pkg::plane_msb;
                            shift_row <= shift_row + 1'b1;
                        end else begin
                            shift_mask <= shift_mask >> 1;
                        end
                    end
                end
                st_latch: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    brightness_timeout u_brightness (
        .clk_in        (clk_in),
        .reset         (reset),
        .row_latch     (row_latch),
        .mask_active   (mask_active),
        .output_enable (output_enable),
        .in_overlap    (in_overlap)
    );

endmodule

//--- matrix_tb.sv
// ======================================================================
// testbench for led_matrix_top, checking lives in matrix_checks
// pixel data comes from a 32-bit Galois LFSR, seed 32'he931
// ======================================================================
`timescale 1ns/1ps

module matrix_tb;

    localparam int clk_period = 8;
    localparam int pixel_words = matrix_pkg::fb_depth;
    localparam int error_accesses = 16;
    // two full frames and a few lines past the row wrap
    localparam int run_latches = 72;
    // one line is about 68 cycles
    localparam int line_cycles = 80;
    localparam int frame_lines = matrix_pkg::panel_halfheight * matrix_pkg::brightness_levels;
    // three cycles per transfer
    localparam int apb_cycles = 3 * (3 * pixel_words + 2 * error_accesses) + 100;
    localparam int timeout_ns = clk_period * (4 * frame_lines * line_cycles + apb_cycles);
    localparam logic [31:0] lfsr_taps = 32'h80200003;

    logic clk_in;
    logic reset;
    logic check_data;
    logic [matrix_pkg::apb_addr_bits-1:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic pixel_clk;
    logic r0;
    logic g0;
    logic b0;
    logic r1;
    logic g1;
    logic b1;
    logic row_latch;
    logic output_enable;
    logic [matrix_pkg::row_bits-1:0] row_address;

    logic [31:0] lfsr_state = 32'he931;
    int failed_tests = 0;
    int total_checks = 0;
    int total_errors = 0;

    led_matrix_top dut (.*);

    matrix_checks panel_checks (.*);

    initial begin
        clk_in = 1'b0;
        forever #(clk_period / 2) clk_in = ~clk_in;
    end

    // runs out only if the scan or the bus stalls
    initial begin
        #(timeout_ns);
        $display("watchdog expired after %0d ns, the scan or APB traffic stalled", timeout_ns);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // one LFSR step per bit taken
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ lfsr_taps) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    // setup, access, then idle
    task automatic apb_transfer(input logic write, input int byte_addr, input logic [31:0] data);
        @(posedge clk_in);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= write;
        paddr <= matrix_pkg::apb_addr_bits'(byte_addr);
        pwdata <= data;
        @(posedge clk_in);
        penable <= 1'b1;
        @(posedge clk_in);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic report_test(input int test, input string name);
        int checks;
        int errors;
        checks = panel_checks.hit_count[test];
        errors = panel_checks.err_count[test];
        total_checks += checks;
        total_errors += errors;
        if (checks == 0) begin
            $display("test %0d %s: no check was reached", test, name);
            failed_tests++;
        end else begin
            $display("test %0d %s: %0d checks, %0d errors", test, name, checks, errors);
            if (errors != 0) begin
                failed_tests++;
            end
        end
    endtask

    initial begin
        logic [31:0] data;
        int addr;
        int start_latches;
        reset <= 1'b1;
        check_data <= 1'b0;
        paddr <= '0;
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
        pwdata <= '0;
        repeat (5) @(posedge clk_in);
        reset <= 1'b0;

        // random pixels everywhere, upper pwdata bits random too
        for (int i = 0; i < pixel_words; i++) begin
            data = next_bits(32);
            apb_transfer(1'b1, i * 4, data);
        end
        for (int i = 0; i < pixel_words; i++) begin
            apb_transfer(1'b0, i * 4, '0);
        end
        // out of range, first one right at the boundary
        for (int i = 0; i < error_accesses; i++) begin
            addr = pixel_words * 4 + ((i == 0) ? 0 : int'(next_bits(9)) * 4);
            data = next_bits(32);
            apb_transfer(1'b1, addr, data);
            apb_transfer(1'b0, addr, '0);
        end
        // dropped writes would show up here
        for (int i = 0; i < pixel_words; i++) begin
            apb_transfer(1'b0, i * 4, '0);
        end
        report_test(1, "apb readback and errors");

        // memory is now frozen, arm the data compare
        @(posedge clk_in);
        check_data <= 1'b1;
        start_latches = panel_checks.latch_count;
        while (panel_checks.latch_count < start_latches + run_latches) begin
            @(posedge clk_in);
        end
        report_test(2, "pixel clock count");
        report_test(3, "shifted data");
        report_test(4, "scan order");
        report_test(5, "lit time");
        report_test(6, "overlap and safety");

        $display("%0d checks, %0d errors, failing tests %0d",
            total_checks, total_errors, failed_tests);
        if (failed_tests == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- pixel_shifter.sv
// ======================================================================
// fetch -> memory (1) -> data bits (2) -> pixel_clk high (3)
// data is held from pixel_clk low through the high cycle
// ======================================================================
`timescale 1ns/1ps

module pixel_shifter (
    input  logic                                clk_in,
    input  logic                                reset,
    scan_if.shift                               scan,
    output logic [matrix_pkg::fb_addr_bits-1:0] rd_addr_upper,
    output logic [matrix_pkg::fb_addr_bits-1:0] rd_addr_lower,
    input  matrix_pkg::pixel_t                  rd_pixel_upper,
    input  matrix_pkg::pixel_t                  rd_pixel_lower,
    output logic                                pixel_clk,
    output logic                                r0,
    output logic                                g0,
    output logic                                b0,
    output logic                                r1,
    output logic                                g1,
    output logic                                b1
);

    logic fetch_d1;
    logic load_d2;
    logic [matrix_pkg::brightness_levels-1:0] mask_d1;

    // row * width + column, lower half one half-panel further on
    assign rd_addr_upper = matrix_pkg::fb_addr_bits'({scan.row, scan.column});
    assign rd_addr_lower = rd_addr_upper + matrix_pkg::fb_addr_bits'(
        matrix_pkg::panel_halfheight * matrix_pkg::panel_width);

    // strobe pipeline
    always_ff @(posedge clk_in) begin
        if (reset) begin
            fetch_d1 <= 1'b0;
            load_d2 <= 1'b0;
            pixel_clk <= 1'b0;
        end else begin
            fetch_d1 <= scan.fetch;
            load_d2 <= fetch_d1;
            pixel_clk <= load_d2;
        end
    end

    // plane select, mask travels with the memory read
    always_ff @(posedge clk_in) begin
        mask_d1 <= scan.mask;
        if (fetch_d1) begin
            r0 <= |(rd_pixel_upper.red & mask_d1);
            g0 <= |(rd_pixel_upper.green & mask_d1);
            b0 <= |(rd_pixel_upper.blue & mask_d1);
            r1 <= |(rd_pixel_lower.red & mask_d1);
            g1 <= |(rd_pixel_lower.green & mask_d1);
            b1 <= |(rd_pixel_lower.blue & mask_d1);
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the led matrix testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module matrix_tb -o matrix_sim
./obj_dir/matrix_sim | tee sim.log
if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1

//--- scan_if.sv
// ======================================================================
// scan position and shift strobes, scan controller to pixel shifter
// all fields change on the rising edge of clk_in
// ======================================================================
`timescale 1ns/1ps

interface scan_if;

    // column being fetched, counts down from the last column
    logic [matrix_pkg::column_bits-1:0] column;
    // line being shifted, not the lit one
    logic [matrix_pkg::row_bits-1:0] row;
    // one-hot bit plane of the line being shifted
    logic [matrix_pkg::brightness_levels-1:0] mask;
    // one cycle per column, alternate cycles
    logic fetch;
    // one cycle after the last fetch
    logic line_done;

    modport ctrl (output column, output row, output mask, output fetch, output line_done);

    modport shift (input column, input row, input mask, input fetch, input line_done);

endinterface

//--- scan_timer.sv
// ======================================================================
// loadable down counter, stops at zero
// a start in the same cycle as the last step wins
// ======================================================================
`timescale 1ns/1ps

module scan_timer #(
    parameter int counter_width = 8
) (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     start,
    input  logic [counter_width-1:0] value,
    output logic [counter_width-1:0] count,
    output logic                     running
);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            // reload, also used to hold the count
            count <= value;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // high for exactly value cycles after a start
    assign running = (count != '0);

endmodule

//--- verilog.f
matrix_pkg.sv
scan_if.sv
scan_timer.sv
brightness_timeout.sv
matrix_scan.sv
frame_buffer.sv
pixel_shifter.sv
led_matrix_top.sv
matrix_checks.sv
matrix_tb.sv
